//--- src/CorePkg.sv
package CorePkg;

    // Datapath widths
    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;

    // Memory word-address widths and depths
    localparam int IMEM_AW    = 6;
    localparam int DMEM_AW    = 4;
    localparam int IMEM_DEPTH = 1 << IMEM_AW;
    localparam int DMEM_DEPTH = 1 << DMEM_AW;

    localparam logic [XLEN-1:0] PC_RESET = 32'h0;

    // R-type funct3 codes
    localparam logic [2:0] F3_ADDSUB = 3'b000;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcodeE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOpE;

    // Coarse ALU class from the control decoder
    typedef enum logic [1:0] {
        CLS_ADD,    // Address calc and addi
        CLS_SUB,    // beq compare
        CLS_FUNCT   // R-type, resolved in execute
    } aluClassE;

endpackage

//--- src/FetchStage.sv
`timescale 1ns/10ps

module FetchStage
    import CorePkg::*;
(
    input  logic               CLK,
    input  logic               arstN,
    input  logic               halt,
    input  logic               branchTaken,
    input  logic [XLEN-1:0]    branchTarget,
    input  logic               progWe,
    input  logic [IMEM_AW-1:0] progAddr,
    input  logic [XLEN-1:0]    progData,
    output logic [XLEN-1:0]    pc,
    output logic [XLEN-1:0]    instr
);

    logic [XLEN-1:0] instrMem [IMEM_DEPTH];
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcNext;

    assign pcPlus4 = pc + XLEN'(4);
    assign pcNext  = branchTaken ? branchTarget : pcPlus4;   // Taken beq wins

    // Halt freezes the PC
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= PC_RESET;
        end else if (!halt) begin
            pc <= pcNext;
        end
    end

    // Program load port works regardless of halt
    always_ff @(posedge CLK) begin
        if (progWe) begin
            instrMem[progAddr] <= progData;
        end
    end

    // Asynchronous read, word index taken from the PC
    assign instr = instrMem[pc[IMEM_AW+1:2]];

    // Branch targets and the reset value must keep the PC aligned
    pcAligned: assert property (
        @(posedge CLK) disable iff (!arstN)
        pc[1:0] == 2'b00
    ) else $error("PC not word aligned: %h", pc);

endmodule

//--- src/DecodeStage.sv
`timescale 1ns/10ps

module DecodeStage
    import CorePkg::*;
(
    input  logic              CLK,
    input  logic              arstN,
    input  logic              halt,
    input  logic [XLEN-1:0]   instr,
    input  logic [XLEN-1:0]   wbData,
    output logic              regWrite,
    output logic [REG_AW-1:0] rd,
    output logic [XLEN-1:0]   rs1Data,
    output logic [XLEN-1:0]   rs2Data,
    output logic [XLEN-1:0]   imm,
    output aluClassE          aluClass,
    output logic [2:0]        funct3,
    output logic              funct7b5,
    output logic              aluSrcImm,
    output logic              isBranch,
    output logic              memWrite,
    output logic              memToReg
);

    opcodeE            opcode;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   immI;
    logic [XLEN-1:0]   immS;
    logic [XLEN-1:0]   immB;
    logic              regWe;
    logic [XLEN-1:0]   regs [1 << REG_AW];

    // Field split
    assign opcode   = opcodeE'(instr[6:0]);
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign funct7b5 = instr[30];

    // Sign-extended immediate formats
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        aluSrcImm = 1'b0;
        isBranch  = 1'b0;
        aluClass  = CLS_ADD;
        imm       = immI;
        case (opcode)
            OP_R: begin
                regWrite = 1'b1;
                aluClass = CLS_FUNCT;
            end
            OP_IMM: begin               // funct3 ignored as only addi is supported
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            OP_LOAD: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                memToReg  = 1'b1;
            end
            OP_STORE: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                imm       = immS;
            end
            OP_BRANCH: begin
                isBranch = 1'b1;
                aluClass = CLS_SUB;
                imm      = immB;
            end
            default: ;                  // Unknown opcode is a no-op
        endcase
    end

    assign regWe = regWrite && !halt && (rd != '0);

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < (1 << REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (regWe) begin
            regs[rd] <= wbData;
        end
    end

    // x0 hardwired to zero
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

    // Committed writeback must never carry unknown bits
    wbDataKnown: assert property (
        @(posedge CLK) disable iff (!arstN)
        regWe |-> !$isunknown(wbData)
    ) else $error("Register x%0d written with unknown data", rd);

endmodule

//--- src/ExecuteStage.sv
`timescale 1ns/10ps

module ExecuteStage
    import CorePkg::*;
(
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1Data,
    input  logic [XLEN-1:0] rs2Data,
    input  logic [XLEN-1:0] imm,
    input  aluClassE        aluClass,
    input  logic [2:0]      funct3,
    input  logic            funct7b5,
    input  logic            aluSrcImm,
    input  logic            isBranch,
    output logic [XLEN-1:0] aluResult,
    output logic            branchTaken,
    output logic [XLEN-1:0] branchTarget
);

    aluOpE           aluOp;
    logic            functLegal;
    logic [XLEN-1:0] opB;

    // ALU control
    always_comb begin
        aluOp      = ALU_ADD;
        functLegal = 1'b1;
        case (aluClass)
            CLS_ADD: aluOp = ALU_ADD;
            CLS_SUB: aluOp = ALU_SUB;
            CLS_FUNCT: begin
                case (funct3)
                    F3_ADDSUB: aluOp = funct7b5 ? ALU_SUB : ALU_ADD;
                    F3_SLT:    aluOp = ALU_SLT;
                    F3_XOR:    aluOp = ALU_XOR;
                    F3_OR:     aluOp = ALU_OR;
                    F3_AND:    aluOp = ALU_AND;
                    default:   functLegal = 1'b0;   // Falls back to add
                endcase
            end
            default: aluOp = ALU_ADD;
        endcase
    end

    assign opB = aluSrcImm ? imm : rs2Data;

    always_comb begin
        case (aluOp)
            ALU_SUB: aluResult = rs1Data - opB;
            ALU_AND: aluResult = rs1Data & opB;
            ALU_OR:  aluResult = rs1Data | opB;
            ALU_XOR: aluResult = rs1Data ^ opB;
            ALU_SLT: aluResult = {{(XLEN-1){1'b0}}, $signed(rs1Data) < $signed(opB)};
            default: aluResult = rs1Data + opB;
        endcase
    end

    // beq compare rides on the subtraction
    assign branchTaken  = isBranch && (aluResult == '0);
    assign branchTarget = pc + imm;

    always_comb begin
        if (aluClass == CLS_FUNCT) begin
            assert final (functLegal)
                else $error("Undefined R-type funct3 %b", funct3);
        end
    end

endmodule

//--- src/MemoryStage.sv
`timescale 1ns/10ps

module MemoryStage
    import CorePkg::*;
(
    input  logic            CLK,
    input  logic            halt,
    input  logic            memWrite,
    input  logic            memToReg,
    input  logic [XLEN-1:0] aluResult,
    input  logic [XLEN-1:0] rs2Data,
    output logic [XLEN-1:0] wbData
);

    logic [XLEN-1:0]    dataMem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] wordAddr;
    logic [XLEN-1:0]    loadData;

    // Byte offset dropped, upper bits wrap
    assign wordAddr = aluResult[DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (memWrite && !halt) begin
            dataMem[wordAddr] <= rs2Data;
        end
    end

    assign loadData = dataMem[wordAddr];    // Asynchronous read

    // Writeback select
    assign wbData = memToReg ? loadData : aluResult;

endmodule

//--- src/SingleCpu.sv
`timescale 1ns/10ps

module SingleCpu
    import CorePkg::*;
(
    input  logic               CLK,
    input  logic               arstN,
    input  logic               halt,
    input  logic               progWe,
    input  logic [IMEM_AW-1:0] progAddr,
    input  logic [XLEN-1:0]    progData,
    output logic [XLEN-1:0]    OUT,
    output logic               wbValid,
    output logic [REG_AW-1:0]  wbReg,
    output logic [XLEN-1:0]    wbData,
    output logic               stValid,
    output logic [XLEN-1:0]    stAddr,
    output logic [XLEN-1:0]    stData
);

    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   instr;
    logic              regWrite;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   rs1Data;
    logic [XLEN-1:0]   rs2Data;
    logic [XLEN-1:0]   imm;
    aluClassE          aluClass;
    logic [2:0]        funct3;
    logic              funct7b5;
    logic              aluSrcImm;
    logic              isBranch;
    logic              memWrite;
    logic              memToReg;
    logic [XLEN-1:0]   aluResult;
    logic              branchTaken;
    logic [XLEN-1:0]   branchTarget;

    FetchStage uFetch (
        .CLK(CLK), .arstN(arstN), .halt(halt),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .instr(instr)
    );

    DecodeStage uDecode (
        .CLK(CLK), .arstN(arstN), .halt(halt), .instr(instr), .wbData(wbData),
        .regWrite(regWrite), .rd(rd), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .imm(imm), .aluClass(aluClass), .funct3(funct3), .funct7b5(funct7b5),
        .aluSrcImm(aluSrcImm), .isBranch(isBranch),
        .memWrite(memWrite), .memToReg(memToReg)
    );

    ExecuteStage uExecute (
        .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
        .aluClass(aluClass), .funct3(funct3), .funct7b5(funct7b5),
        .aluSrcImm(aluSrcImm), .isBranch(isBranch),
        .aluResult(aluResult), .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    MemoryStage uMemory (
        .CLK(CLK), .halt(halt), .memWrite(memWrite), .memToReg(memToReg),
        .aluResult(aluResult), .rs2Data(rs2Data), .wbData(wbData)
    );

    // Trace ports describe the instruction retiring at the next edge
    assign OUT     = instr;
    assign wbValid = regWrite && !halt && (rd != '0);
    assign wbReg   = rd;
    assign stValid = memWrite && !halt;
    assign stAddr  = {aluResult[XLEN-1:2], 2'b00};
    assign stData  = rs2Data;

    // Halt must hold the fetch position across stages
    haltHoldsPc: assert property (
        @(posedge CLK) disable iff (!arstN)
        halt |=> $stable(pc)
    ) else $error("PC moved during halt");

endmodule

//--- bench/tbSingleCpu.sv
`timescale 1ns/10ps

module tbSingleCpu;

    localparam int          CLK_PERIOD = 100;
    localparam int          NUM_PROGS  = 4;
    localparam int          PROG_LEN   = 40;    // Seeds, body and final loop
    localparam int          TIMEOUT    = 200;
    localparam logic [31:0] SEED       = 32'he7c0f9fd;
    localparam logic [31:0] LOOP_WORD  = 32'h00000063;  // beq x0, x0, 0
    localparam logic [6:0]  OPC_R      = 7'b0110011;
    localparam logic [6:0]  OPC_IMM    = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
    localparam logic [6:0]  OPC_STORE  = 7'b0100011;
    localparam logic [6:0]  OPC_BRANCH = 7'b1100011;

    logic        CLK;
    logic        arstN;
    logic        halt;
    logic        progWe;
    logic [5:0]  progAddr;
    logic [31:0] progData;
    logic [31:0] OUT;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic        stValid;
    logic [31:0] stAddr;
    logic [31:0] stData;

    logic [31:0] lfsrState;
    logic [31:0] progMem [PROG_LEN];
    logic [31:0] modelRegs [8];     // x0 to x7 only
    logic [31:0] modelMem [16];     // Not cleared between programs, like the DUT

    // Expected retire and store records in execution order
    logic [31:0] expInstr [$];
    logic        expWbValid [$];
    logic [4:0]  expWbReg [$];
    logic [31:0] expWbData [$];
    logic        expStValid [$];
    logic [31:0] expStAddr [$];
    logic [31:0] expStData [$];

    int checks;
    int errors;
    int testErrors;
    int passed;
    int failed;

    SingleCpu dut0 (
        .CLK(CLK), .arstN(arstN), .halt(halt),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .OUT(OUT), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .stValid(stValid), .stAddr(stAddr), .stData(stData)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);   // One step per bit
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_R};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input int rs1,
                                         input logic [2:0] f3, input int rd, input logic [6:0] opc);
        return {imm, 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input int rs2, input int rs1);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    // 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt
    function automatic logic [31:0] aluModel(input int op, input logic [31:0] a, input logic [31:0] b);
        case (op)
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a + b;
        endcase
    endfunction

    task automatic pushRecord(input logic [31:0] word, input logic wv, input int rd,
                              input logic [31:0] wd, input logic sv,
                              input logic [31:0] sa, input logic [31:0] sd);
        expInstr.push_back(word);
        expWbValid.push_back(wv);
        expWbReg.push_back(5'(rd));
        expWbData.push_back(wd);
        expStValid.push_back(sv);
        expStAddr.push_back(sa);
        expStData.push_back(sd);
    endtask

    task automatic retireWrite(input logic [31:0] word, input int rd, input logic [31:0] val);
        if (rd != 0) begin
            modelRegs[rd] = val;    // x0 stays zero
        end
        pushRecord(word, rd != 0, rd, val, 1'b0, '0, '0);
    endtask

    // Builds the program and runs the ISA model on it in the same pass
    task automatic genProgram();
        int          modelPc;
        int          kind;
        int          op;
        int          rd;
        int          rs1;
        int          rs2;
        int          off;
        int          idx;
        int          storeIdx [$];
        bit          exec;
        bit          taken;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic [31:0] word;
        logic [31:0] addr;
        expInstr.delete();
        expWbValid.delete();
        expWbReg.delete();
        expWbData.delete();
        expStValid.delete();
        expStAddr.delete();
        expStData.delete();
        for (int r = 0; r < 8; r++) begin
            modelRegs[r] = '0;
        end
        modelPc = 0;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            exec  = (i == modelPc);
            taken = 1'b0;
            off   = 4;
            kind  = (i < 8) ? 2 : int'(randBits(3));
            rd    = randBits(3);
            rs1   = randBits(3);
            rs2   = randBits(3);
            imm   = randBits(12);
            if (i < 8) begin    // Seed x0 to x7
                rd  = i;
                rs1 = 0;
            end
            if (kind == 4 && storeIdx.size() == 0) kind = 2;  // Nothing stored yet
            case (kind)
                2, 7: begin
                    word = encI(imm, rs1, 3'b000, rd, OPC_IMM);
                    if (exec) retireWrite(word, rd, modelRegs[rs1] + {{20{imm[11]}}, imm});
                end
                3: begin
                    word = encS(imm, rs2, rs1);
                    if (exec) begin
                        addr = modelRegs[rs1] + {{20{imm[11]}}, imm};
                        modelMem[addr[5:2]] = modelRegs[rs2];
                        storeIdx.push_back(int'(addr[5:2]));
                        pushRecord(word, 1'b0, 0, '0, 1'b1, {addr[31:2], 2'b00}, modelRegs[rs2]);
                    end
                end
                4: begin
                    idx  = storeIdx[randBits(4) % storeIdx.size()];
                    imm  = 12'(idx * 4 + 64 * randBits(3));   // Upper bits alias
                    word = encI(imm, 0, 3'b010, rd, OPC_LOAD);
                    if (exec) retireWrite(word, rd, modelMem[idx]);
                end
                5: begin
                    if (randBits(1)) rs2 = rs1;
                    off = 4 * (1 + randBits(2));
                    if (i + off / 4 > PROG_LEN - 1) off = 4;  // Stay inside the program
                    word  = encB(13'(off), rs2, rs1);
                    taken = (modelRegs[rs1] == modelRegs[rs2]);
                    if (exec) pushRecord(word, 1'b0, 0, '0, 1'b0, '0, '0);
                end
                default: begin
                    op = randBits(3) % 6;
                    case (op)
                        2: f3 = 3'b111;
                        3: f3 = 3'b110;
                        4: f3 = 3'b100;
                        5: f3 = 3'b010;
                        default: f3 = 3'b000;
                    endcase
                    word = encR((op == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
                    if (exec) retireWrite(word, rd, aluModel(op, modelRegs[rs1], modelRegs[rs2]));
                end
            endcase
            progMem[i] = word;
            if (exec) modelPc = taken ? i + off / 4 : i + 1;
        end
        progMem[PROG_LEN - 1] = LOOP_WORD;
    endtask

    task automatic stepCycle(input logic haltLevel);
        @(posedge CLK);
        #5;
        halt = haltLevel;
        @(negedge CLK);     // Outputs settled mid cycle
    endtask

    task automatic applyReset();
        @(posedge CLK);
        #5;
        halt  = 1'b1;
        arstN = 1'b0;
        repeat (10) @(posedge CLK);
        #5;
        arstN = 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge CLK);
            #5;
            progWe   = 1'b1;
            progAddr = 6'(i);
            progData = progMem[i];
        end
        @(posedge CLK);
        #5;
        progWe = 1'b0;
        @(negedge CLK);
    endtask

    task automatic compareField(input string field, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            testErrors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, field, got, exp);
        end
    endtask

    task automatic checkRecord(input int pos);
        compareField("OUT", OUT, expInstr[pos]);
        compareField("wbValid", 32'(wbValid), 32'(expWbValid[pos]));
        if (expWbValid[pos]) begin
            compareField("wbReg", 32'(wbReg), 32'(expWbReg[pos]));
            compareField("wbData", wbData, expWbData[pos]);
        end
        compareField("stValid", 32'(stValid), 32'(expStValid[pos]));
        if (expStValid[pos]) begin
            compareField("stAddr", stAddr, expStAddr[pos]);
            compareField("stData", stData, expStData[pos]);
        end
    endtask

    // Halted core shows the waiting instruction and no valids
    task automatic checkFrozen(input int pos);
        compareField("OUT while halted", OUT, expInstr[pos]);
        compareField("wbValid while halted", 32'(wbValid), 32'd0);
        compareField("stValid while halted", 32'(stValid), 32'd0);
    endtask

    initial begin
        int pos;
        int cycles;
        int frozen;
        int freezeAt;
        int freezeLen;
        bit done;
        arstN     = 1'b0;
        halt      = 1'b1;
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = '0;
        lfsrState = SEED;
        checks    = 0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        for (int t = 0; t < NUM_PROGS; t++) begin
            testErrors = 0;
            genProgram();
            applyReset();
            loadProgram();
            checkFrozen(0);
            freezeAt  = 1 + randBits(5) % (expInstr.size() - 1);
            freezeLen = 1 + randBits(3);
            pos       = 0;
            cycles    = 0;
            frozen    = 0;
            done      = 1'b0;
            while (!done && cycles < TIMEOUT) begin
                if (pos == freezeAt && frozen < freezeLen) begin
                    stepCycle(1'b1);
                    frozen++;
                    checkFrozen(pos);
                end else begin
                    stepCycle(1'b0);
                    if (pos < expInstr.size()) begin
                        checkRecord(pos);
                        pos++;
                    end else begin
                        compareField("OUT at end", OUT, LOOP_WORD);
                        done = 1'b1;
                    end
                end
                cycles++;
            end
            if (!done) begin
                testErrors++;
                $display("Program %0d did not reach its final self-loop within %0d cycles",
                         t, TIMEOUT);
            end
            errors += testErrors;
            if (testErrors == 0) passed++;
            else failed++;
            $display("Test %0d: %0d instructions, halted %0d cycles at %0d, %0d errors",
                     t, pos, freezeLen, freezeAt, testErrors);
        end
        $display("Tests %0d passed, %0d failed, %0d checks, %0d errors",
                 passed, failed, checks, errors);
        if (failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
src/CorePkg.sv
src/FetchStage.sv
src/DecodeStage.sv
src/ExecuteStage.sv
src/MemoryStage.sv
src/SingleCpu.sv
bench/tbSingleCpu.sv

//--- Bender.yml
package:
  name: single_cpu

sources:
  # Shared package first
  - src/CorePkg.sv

  # Stage modules and the top level
  - src/FetchStage.sv
  - src/DecodeStage.sv
  - src/ExecuteStage.sv
  - src/MemoryStage.sv
  - src/SingleCpu.sv

  # Testbench
  - target: simulation
    files:
      - bench/tbSingleCpu.sv
